//--- logic/scb_pkg.sv
// Widths and word types shared by the store commit buffer and its testbench.
package scb_pkg;

    // ----------------------------------------
    // address layout
    // ----------------------------------------

    localparam int ADDR_W = 32;     // byte address width.
    localparam int WORD_OFF = 3;    // byte offset bits inside one word.
    localparam int WORD_BYTES = 8;

    // an entry is tagged by the address of its word, without the byte offset.
    typedef logic [ADDR_W-WORD_OFF-1:0] word_addr_t;

    // ----------------------------------------
    // word payload
    // ----------------------------------------

    typedef logic [8*WORD_BYTES-1:0] data_t;
    typedef logic [WORD_BYTES-1:0] mask_t;  // one bit per byte lane.

endpackage

//--- logic/scb_ifs.sv
`timescale 1ns/1ps

// Write command from the tag array into the entry storage.
interface scb_write_if import scb_pkg::*; #(parameter int DEPTH = 8);
    logic wen;
    logic [$clog2(DEPTH)-1:0] windex;
    logic fresh;    // the entry is newly allocated by this write.
    data_t wdata;
    mask_t wmask;

    modport tag_side (output wen, windex, fresh, wdata, wmask);
    modport data_side (input wen, windex, fresh, wdata, wmask);
    modport age_side (input wen, windex);
endinterface

// Forward and drain reads of the entry storage.
interface scb_read_if import scb_pkg::*; #(parameter int DEPTH = 8);
    logic fwd_req;
    logic [$clog2(DEPTH)-1:0] fwd_idx;
    data_t fwd_data;
    mask_t fwd_mask;
    logic [$clog2(DEPTH)-1:0] drain_idx;
    data_t drain_data;
    mask_t drain_mask;

    modport tag_side (output fwd_req, fwd_idx);
    modport data_side (input fwd_req, fwd_idx, drain_idx,
                       output fwd_data, fwd_mask, drain_data, drain_mask);
    modport drain_side (output drain_idx, input drain_data, drain_mask);
endinterface

//--- logic/scb_tag_array.sv
`timescale 1ns/1ps

module scb_tag_array import scb_pkg::*; #(
    parameter int DEPTH = 8,
    localparam int IDX_W = $clog2(DEPTH)
) (
    input logic clk,
    input logic rst,
    input logic st_en,
    input word_addr_t st_addr,
    input data_t st_data,
    input mask_t st_mask,
    input logic ld_en,
    input word_addr_t ld_addr,
    input logic drain_start,
    input logic drain_done,
    input logic drain_retry,
    input logic [IDX_W-1:0] drain_idx,
    output logic st_stall,
    output logic [DEPTH-1:0] valid,
    output logic empty,
    output word_addr_t drain_addr,
    scb_write_if.tag_side wr,
    scb_read_if.tag_side rd
);

    word_addr_t tags [DEPTH];
    logic [DEPTH-1:0] writing;
    logic [DEPTH-1:0] busy;
    logic [DEPTH-1:0] st_hit;
    logic [DEPTH-1:0] ld_hit;
    logic hit;
    logic hit_busy;
    logic full;
    logic alloc;
    logic [IDX_W-1:0] hit_idx;
    logic [IDX_W-1:0] free_idx;

    function automatic logic [IDX_W-1:0] lowest(input logic [DEPTH-1:0] vec);
        logic [IDX_W-1:0] idx;
        idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = IDX_W'(i);
            end
        end
        return idx;
    endfunction

    // ----------------------------------------
    // store lookup
    // ----------------------------------------

    // an entry picked for drain this cycle is frozen like one already in flight.
    always_comb begin
        busy = writing;
        if (drain_start) begin
            busy[drain_idx] = 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            st_hit[i] = valid[i] && (tags[i] == st_addr);
            ld_hit[i] = valid[i] && (tags[i] == ld_addr);
        end
    end

    assign hit = |st_hit;
    assign hit_busy = |(st_hit & busy);
    assign hit_idx = lowest(st_hit);    // at most one entry holds a given word.
    assign free_idx = lowest(~valid);
    assign full = &valid;

    assign st_stall = st_en & (hit_busy | (~hit & full));

    assign wr.wen = st_en & ~st_stall;
    assign wr.windex = hit ? hit_idx : free_idx;
    assign wr.fresh = ~hit;
    assign wr.wdata = st_data;
    assign wr.wmask = st_mask;

    assign alloc = wr.wen & ~hit;

    // ----------------------------------------
    // entry state
    // ----------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
            writing <= '0;
        end else begin
            if (alloc) begin
                valid[free_idx] <= 1'b1;
                writing[free_idx] <= 1'b0;
            end
            if (drain_start) begin
                writing[drain_idx] <= 1'b1;
            end
            if (drain_retry) begin
                writing[drain_idx] <= 1'b0;     // the entry becomes eligible again.
            end
            if (drain_done) begin
                valid[drain_idx] <= 1'b0;
                writing[drain_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            tags[free_idx] <= st_addr;
        end
    end

    assign empty = ~(|valid);
    assign drain_addr = tags[drain_idx];

    // The match is sampled by the data array on the same edge as the load.
    assign rd.fwd_req = ld_en & (|ld_hit);
    assign rd.fwd_idx = lowest(ld_hit);

endmodule

//--- logic/scb_data_array.sv
`timescale 1ns/1ps

module scb_data_array import scb_pkg::*; #(
    parameter int DEPTH = 8
) (
    input logic clk,
    input logic rst,
    scb_write_if.data_side wr,
    scb_read_if.data_side rd
);

    data_t data_mem [DEPTH];
    mask_t byte_valid [DEPTH];

    // ----------------------------------------
    // write port
    // ----------------------------------------

    // Masked bytes are written. A fresh entry drops whatever it held before.
    always_ff @(posedge clk) begin
        if (wr.wen) begin
            for (int j = 0; j < WORD_BYTES; j++) begin
                if (wr.wmask[j]) begin
                    data_mem[wr.windex][8*j +: 8] <= wr.wdata[8*j +: 8];
                    byte_valid[wr.windex][j] <= 1'b1;
                end else if (wr.fresh) begin
                    byte_valid[wr.windex][j] <= 1'b0;
                end
            end
        end
    end

    // ----------------------------------------
    // read ports
    // ----------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd.fwd_mask <= '0;
        end else if (rd.fwd_req) begin
            rd.fwd_mask <= byte_valid[rd.fwd_idx];
        end else begin
            rd.fwd_mask <= '0;  // a miss forwards nothing.
        end
    end

    always_ff @(posedge clk) begin
        rd.fwd_data <= data_mem[rd.fwd_idx];
    end

    assign rd.drain_data = data_mem[rd.drain_idx];
    assign rd.drain_mask = byte_valid[rd.drain_idx];

endmodule

//--- logic/scb_age_timer.sv
`timescale 1ns/1ps

module scb_age_timer #(
    parameter int DEPTH = 8,
    parameter int THRESH = 5,
    parameter int AGE_W = 4
) (
    input logic clk,
    input logic rst,
    input logic flush,
    scb_write_if.age_side wr,
    input logic [DEPTH-1:0] valid,
    output logic [DEPTH-1:0] eligible
);

    localparam int IDX_W = $clog2(DEPTH);
    localparam int COUNT_W = $clog2(DEPTH + 1);

    // one-hot shift counter per entry, bit 0 set means the entry has aged.
    logic [AGE_W:0] age [DEPTH];
    logic [COUNT_W-1:0] occupancy;
    logic over_thresh;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                age[i] <= (AGE_W+1)'(1);
            end
        end else if (wr.wen) begin
            for (int i = 0; i < DEPTH; i++) begin
                if (wr.windex == IDX_W'(i)) begin
                    age[i] <= {1'b1, {AGE_W{1'b0}}};
                end else if (!age[i][0]) begin
                    age[i] <= age[i] >> 1;
                end
            end
        end
    end

    always_comb begin
        occupancy = '0;
        for (int i = 0; i < DEPTH; i++) begin
            occupancy = occupancy + COUNT_W'(valid[i]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            over_thresh <= 1'b0;
        end else begin
            over_thresh <= int'(occupancy) > THRESH;
        end
    end

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            eligible[i] = valid[i] & (age[i][0] | over_thresh | flush);
        end
    end

endmodule

//--- logic/scb_drain_fsm.sv
`timescale 1ns/1ps

module scb_drain_fsm import scb_pkg::*; #(
    parameter int DEPTH = 8,
    localparam int IDX_W = $clog2(DEPTH)
) (
    input logic clk,
    input logic rst,
    input logic [DEPTH-1:0] eligible,
    input logic dc_ready,
    input logic dc_success,
    input logic dc_conflict,
    input word_addr_t drain_addr,
    output logic drain_start,
    output logic drain_done,
    output logic drain_retry,
    output logic [IDX_W-1:0] drain_idx,
    output logic dc_req,
    output logic [ADDR_W-1:0] dc_addr,
    output data_t dc_data,
    output mask_t dc_mask,
    scb_read_if.drain_side rd
);

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_wait
    } state_t;

    state_t state;
    state_t state_next;
    logic [IDX_W-1:0] idx_q;
    logic [IDX_W-1:0] pick_idx;
    logic go;

    always_comb begin
        pick_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (eligible[i]) begin
                pick_idx = IDX_W'(i);
            end
        end
    end

    // Selection only happens in IDLE, where no entry is in flight.
    assign go = (state == st_idle) & dc_ready & (|eligible);

    assign drain_idx = (state == st_idle) ? pick_idx : idx_q;
    assign rd.drain_idx = drain_idx;

    assign drain_start = go;
    assign drain_done = (state == st_wait) & dc_success;
    assign drain_retry = (state == st_wait) & dc_conflict & ~dc_success;

    // ----------------------------------------
    // state machine
    // ----------------------------------------

    always_comb begin
        state_next = state;
        case (state)
            st_idle: if (go) state_next = st_req;
            st_req: state_next = st_wait;   // the request lasts one cycle.
            st_wait: if (dc_success || dc_conflict) state_next = st_idle;
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            dc_req <= 1'b0;
        end else begin
            state <= state_next;
            dc_req <= go;
        end
    end

    // The entry is frozen from this edge on, so the captured word stays current.
    always_ff @(posedge clk) begin
        if (go) begin
            idx_q <= pick_idx;
            dc_addr <= {drain_addr, {WORD_OFF{1'b0}}};
            dc_data <= rd.drain_data;
            dc_mask <= rd.drain_mask;
        end
    end

endmodule

//--- logic/store_commit_buffer.sv
`timescale 1ns/1ps

module store_commit_buffer import scb_pkg::*; #(
    parameter int DEPTH = 8,
    parameter int THRESH = 5,
    parameter int AGE_W = 4
) (
    input logic clk,
    input logic rst,
    input logic flush,
    input logic st_en,
    input logic [ADDR_W-1:0] st_addr,
    input data_t st_data,
    input mask_t st_mask,
    input logic ld_en,
    input logic [ADDR_W-1:0] ld_addr,
    input logic dc_ready,
    input logic dc_success,
    input logic dc_conflict,
    output logic st_stall,
    output data_t ld_fwd_data,
    output mask_t ld_fwd_mask,
    output logic dc_req,
    output logic [ADDR_W-1:0] dc_addr,
    output data_t dc_data,
    output mask_t dc_mask,
    output logic empty
);

    localparam int IDX_W = $clog2(DEPTH);

    word_addr_t st_word;
    word_addr_t ld_word;
    word_addr_t drain_addr;
    logic [DEPTH-1:0] valid;
    logic [DEPTH-1:0] eligible;
    logic drain_start;
    logic drain_done;
    logic drain_retry;
    logic [IDX_W-1:0] drain_idx;

    scb_write_if #(.DEPTH(DEPTH)) wr_bus ();
    scb_read_if #(.DEPTH(DEPTH)) rd_bus ();

    // byte offsets are dropped, the word mask carries the lanes.
    assign st_word = st_addr[ADDR_W-1:WORD_OFF];
    assign ld_word = ld_addr[ADDR_W-1:WORD_OFF];

    scb_tag_array #(.DEPTH(DEPTH)) u_tags (
        .clk(clk),
        .rst(rst),
        .st_en(st_en),
        .st_addr(st_word),
        .st_data(st_data),
        .st_mask(st_mask),
        .ld_en(ld_en),
        .ld_addr(ld_word),
        .drain_start(drain_start),
        .drain_done(drain_done),
        .drain_retry(drain_retry),
        .drain_idx(drain_idx),
        .st_stall(st_stall),
        .valid(valid),
        .empty(empty),
        .drain_addr(drain_addr),
        .wr(wr_bus.tag_side),
        .rd(rd_bus.tag_side)
    );

    scb_data_array #(.DEPTH(DEPTH)) u_data (
        .clk(clk),
        .rst(rst),
        .wr(wr_bus.data_side),
        .rd(rd_bus.data_side)
    );

    scb_age_timer #(.DEPTH(DEPTH), .THRESH(THRESH), .AGE_W(AGE_W)) u_age (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .wr(wr_bus.age_side),
        .valid(valid),
        .eligible(eligible)
    );

    scb_drain_fsm #(.DEPTH(DEPTH)) u_drain (
        .clk(clk),
        .rst(rst),
        .eligible(eligible),
        .dc_ready(dc_ready),
        .dc_success(dc_success),
        .dc_conflict(dc_conflict),
        .drain_addr(drain_addr),
        .drain_start(drain_start),
        .drain_done(drain_done),
        .drain_retry(drain_retry),
        .drain_idx(drain_idx),
        .dc_req(dc_req),
        .dc_addr(dc_addr),
        .dc_data(dc_data),
        .dc_mask(dc_mask),
        .rd(rd_bus.drain_side)
    );

    assign ld_fwd_data = rd_bus.fwd_data;
    assign ld_fwd_mask = rd_bus.fwd_mask;

endmodule

//--- bench/scb_model.svh
`ifndef SCB_MODEL_SVH
`define SCB_MODEL_SVH

typedef enum int {op_store, op_load, op_ready, op_flush, op_wait} op_t;

typedef struct {
    op_t op;
    logic [ADDR_W-1:0] addr;    // byte address, or the word count a wait row drains down to.
    data_t data;                // store data, or the level of a ready or flush row.
    mask_t mask;
    logic flag;                 // the next cache request is answered with a conflict.
    string name;
} row_t;

row_t rows [$];

// ----------------------------------------
// reference model
// ----------------------------------------

data_t mdl_data [word_addr_t];
mask_t mdl_mask [word_addr_t];
logic inflight;                 // a cache request is outstanding.
word_addr_t inflight_word;

function automatic data_t lanes(input mask_t m);
    data_t d;
    for (int j = 0; j < WORD_BYTES; j++) begin
        d[8*j +: 8] = {8{m[j]}};
    end
    return d;
endfunction

function automatic mask_t buffered_mask(input word_addr_t w);
    return mdl_mask.exists(w) ? mdl_mask[w] : '0;
endfunction

function automatic data_t buffered_data(input word_addr_t w);
    return mdl_data.exists(w) ? mdl_data[w] : '0;
endfunction

function automatic int word_count();
    return mdl_mask.num();
endfunction

// merge into the word, a new word starts with no valid bytes.
function automatic void store_word(input word_addr_t w, input data_t d, input mask_t m);
    mdl_data[w] = (buffered_data(w) & ~lanes(m)) | (d & lanes(m));
    mdl_mask[w] = buffered_mask(w) | m;
endfunction

function automatic void drop_word(input word_addr_t w);
    mdl_data.delete(w);
    mdl_mask.delete(w);
endfunction

// A hit stalls only on the word in flight, a miss stalls only when every entry is taken.
function automatic logic expect_stall(input word_addr_t w);
    if (mdl_mask.exists(w)) begin
        return inflight && (inflight_word == w);
    end
    return word_count() >= DEPTH;
endfunction

// ----------------------------------------
// stimulus table
// ----------------------------------------

function automatic void add_row(input op_t op, input logic [ADDR_W-1:0] addr, input data_t data,
                                input mask_t mask, input logic flag, input string name);
    row_t r;
    r.op = op;
    r.addr = addr;
    r.data = data;
    r.mask = mask;
    r.flag = flag;
    r.name = name;
    rows.push_back(r);
endfunction

// columns are operation, byte address or count, data or level, mask, conflict flag, name.
function automatic void build_table();
    add_row(op_store, 32'h1000_0040, 64'h1111_2222_3333_4444, 8'h0F, 1'b0, "merge_lo");
    add_row(op_store, 32'h1000_0043, 64'hAAAA_BBBB_CCCC_DDDD, 8'hF0, 1'b0, "merge_hi");
    add_row(op_load, 32'h1000_0040, '0, '0, 1'b0, "merge_fwd");
    add_row(op_store, 32'h1000_0044, 64'h5555_6666_7777_8888, 8'h3C, 1'b0, "merge_overlap");
    add_row(op_load, 32'h1000_0047, '0, '0, 1'b0, "overlap_fwd");
    add_row(op_load, 32'h2000_0000, '0, '0, 1'b0, "fwd_miss");
    add_row(op_store, 32'h1000_0048, 64'h0101_0101_0101_0101, 8'hFF, 1'b0, "fill_1");
    add_row(op_store, 32'h1000_0050, 64'h0202_0202_0202_0202, 8'h0F, 1'b0, "fill_2");
    add_row(op_store, 32'h1000_0058, 64'h0303_0303_0303_0303, 8'hF0, 1'b0, "fill_3");
    add_row(op_store, 32'h1000_0060, 64'h0404_0404_0404_0404, 8'h81, 1'b0, "fill_4");
    add_row(op_store, 32'h1000_0068, 64'h0505_0505_0505_0505, 8'h18, 1'b0, "fill_5");
    add_row(op_store, 32'h1000_0070, 64'h0606_0606_0606_0606, 8'hFF, 1'b0, "fill_6");
    add_row(op_store, 32'h1000_0078, 64'h0707_0707_0707_0707, 8'h42, 1'b0, "fill_7");
    add_row(op_store, 32'h1000_0080, 64'h0808_0808_0808_0808, 8'hFF, 1'b0, "full_stall");
    add_row(op_store, 32'h1000_0058, 64'h0000_0000_0000_00EE, 8'h01, 1'b0, "full_merge");
    add_row(op_load, 32'h1000_0058, '0, '0, 1'b0, "full_fwd");
    add_row(op_flush, '0, 64'd1, '0, 1'b0, "flush_on");
    add_row(op_ready, '0, 64'd1, '0, 1'b0, "ready_on");
    add_row(op_wait, 32'd0, '0, '0, 1'b0, "flush_drain");
    add_row(op_flush, '0, 64'd0, '0, 1'b0, "flush_off");
    add_row(op_ready, '0, 64'd0, '0, 1'b0, "ready_off");
    add_row(op_store, 32'h3000_0100, 64'hDEAD_BEEF_0BAD_F00D, 8'hFF, 1'b0, "retry_store");
    add_row(op_flush, '0, 64'd1, '0, 1'b0, "retry_flush");
    add_row(op_ready, '0, 64'd1, '0, 1'b1, "retry_ready");
    add_row(op_store, 32'h3000_0100, 64'h0000_0000_0000_0099, 8'h01, 1'b0, "retry_stall");
    add_row(op_wait, 32'd0, '0, '0, 1'b0, "retry_drain");
    add_row(op_flush, '0, 64'd0, '0, 1'b0, "retry_done");
    add_row(op_store, 32'h4000_0000, 64'h1000_0000_0000_0001, 8'hFF, 1'b0, "thresh_1");
    add_row(op_store, 32'h4000_0008, 64'h2000_0000_0000_0002, 8'hFF, 1'b0, "thresh_2");
    add_row(op_store, 32'h4000_0010, 64'h3000_0000_0000_0003, 8'h0F, 1'b0, "thresh_3");
    add_row(op_store, 32'h4000_0018, 64'h4000_0000_0000_0004, 8'hF0, 1'b0, "thresh_4");
    add_row(op_store, 32'h4000_0020, 64'h5000_0000_0000_0005, 8'hFF, 1'b0, "thresh_5");
    add_row(op_store, 32'h4000_0028, 64'h6000_0000_0000_0006, 8'h3C, 1'b0, "thresh_6");
    add_row(op_wait, 32'd5, '0, '0, 1'b0, "thresh_drain");
    add_row(op_flush, '0, 64'd1, '0, 1'b0, "thresh_flush");
    add_row(op_wait, 32'd0, '0, '0, 1'b0, "thresh_empty");
    add_row(op_flush, '0, 64'd0, '0, 1'b0, "thresh_done");
    add_row(op_store, 32'h5000_0000, 64'h0A0A_0A0A_0A0A_0A0A, 8'hFF, 1'b0, "age_single");
    add_row(op_store, 32'h5000_0100, 64'h0000_0000_0000_00B1, 8'h01, 1'b0, "age_other_1");
    add_row(op_store, 32'h5000_0100, 64'h0000_0000_0000_B200, 8'h02, 1'b0, "age_other_2");
    add_row(op_store, 32'h5000_0100, 64'h0000_0000_00B3_0000, 8'h04, 1'b0, "age_other_3");
    add_row(op_store, 32'h5000_0100, 64'h0000_0000_B400_0000, 8'h08, 1'b0, "age_other_4");
    add_row(op_wait, 32'd1, '0, '0, 1'b0, "age_drain");
    add_row(op_load, 32'h5000_0100, '0, '0, 1'b0, "age_kept");
    add_row(op_load, 32'h5000_0000, '0, '0, 1'b0, "age_gone");
    add_row(op_flush, '0, 64'd1, '0, 1'b0, "final_flush");
    add_row(op_wait, 32'd0, '0, '0, 1'b0, "final_drain");
endfunction

`endif

//--- bench/scb_tb.sv
`timescale 1ns/1ps

module scb_tb import scb_pkg::*; ();

    localparam int DEPTH = 8;
    localparam int THRESH = 5;
    localparam int AGE_W = 4;
    localparam int WAIT_LIMIT = 400;    // cycles allowed for one wait row.

    logic clk;
    logic rst;
    logic flush;
    logic st_en;
    logic [ADDR_W-1:0] st_addr;
    data_t st_data;
    mask_t st_mask;
    logic ld_en;
    logic [ADDR_W-1:0] ld_addr;
    logic dc_ready;
    logic dc_success;
    logic dc_conflict;
    logic st_stall;
    data_t ld_fwd_data;
    mask_t ld_fwd_mask;
    logic dc_req;
    logic [ADDR_W-1:0] dc_addr;
    data_t dc_data;
    mask_t dc_mask;
    logic empty;

    int value_errors;
    int other_errors;
    logic timed_out;
    logic [31:0] lfsr;
    logic conflict_next;
    logic retry_pending;
    word_addr_t retry_word;
    string cur_name;

    `include "scb_model.svh"

    store_commit_buffer #(.DEPTH(DEPTH), .THRESH(THRESH), .AGE_W(AGE_W)) uut (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .st_en(st_en),
        .st_addr(st_addr),
        .st_data(st_data),
        .st_mask(st_mask),
        .ld_en(ld_en),
        .ld_addr(ld_addr),
        .dc_ready(dc_ready),
        .dc_success(dc_success),
        .dc_conflict(dc_conflict),
        .st_stall(st_stall),
        .ld_fwd_data(ld_fwd_data),
        .ld_fwd_mask(ld_fwd_mask),
        .dc_req(dc_req),
        .dc_addr(dc_addr),
        .dc_data(dc_data),
        .dc_mask(dc_mask),
        .empty(empty)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int draw_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);     // one step for every bit taken.
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("ERR %s: expected %h, actual %h", name, exp, act);
        value_errors++;
    endtask

    // ----------------------------------------
    // cache responder
    // ----------------------------------------

    task automatic check_request(input word_addr_t w);
        if (dc_addr[WORD_OFF-1:0] !== '0) begin
            report_mismatch({cur_name, "/dc_offset"}, 64'(0), 64'(dc_addr[WORD_OFF-1:0]));
        end
        if (retry_pending && w !== retry_word) begin
            report_mismatch({cur_name, "/retry_word"}, 64'(retry_word), 64'(w));
        end
        if (!mdl_mask.exists(w)) begin
            $display("cache request in %s for word %h, which is not buffered", cur_name, w);
            other_errors++;
        end else begin
            if (dc_mask !== mdl_mask[w]) begin
                report_mismatch({cur_name, "/dc_mask"}, 64'(mdl_mask[w]), 64'(dc_mask));
            end
            if ((dc_data & lanes(dc_mask)) !== (mdl_data[w] & lanes(mdl_mask[w]))) begin
                report_mismatch({cur_name, "/dc_data"}, mdl_data[w] & lanes(mdl_mask[w]),
                                dc_data & lanes(dc_mask));
            end
        end
    endtask

    initial begin
        int delay;
        word_addr_t w;
        forever begin
            @(negedge clk);
            if (!rst && dc_req === 1'b1) begin
                w = dc_addr[ADDR_W-1:WORD_OFF];
                check_request(w);
                inflight = 1'b1;
                inflight_word = w;
                @(negedge clk);
                if (dc_req !== 1'b0) begin
                    $display("dc_req for word %h stayed high for more than one cycle", w);
                    other_errors++;
                end
                delay = draw_bits(2);
                repeat (delay) @(negedge clk);
                if (conflict_next) begin
                    dc_conflict = 1'b1;
                    conflict_next = 1'b0;
                    retry_pending = 1'b1;
                    retry_word = w;
                end else begin
                    dc_success = 1'b1;
                end
                @(negedge clk);
                if (dc_success) begin
                    drop_word(w);   // the buffer frees the entry on the edge just passed.
                    retry_pending = 1'b0;
                end
                dc_success = 1'b0;
                dc_conflict = 1'b0;
                inflight = 1'b0;
            end
        end
    end

    // ----------------------------------------
    // table rows
    // ----------------------------------------

    task automatic apply_row(input row_t row);
        word_addr_t w;
        logic exp_stall;
        data_t exp_data;
        mask_t exp_mask;
        int cycles;
        w = row.addr[ADDR_W-1:WORD_OFF];
        @(negedge clk);
        cur_name = row.name;
        st_en = 1'b0;
        ld_en = 1'b0;
        case (row.op)
            op_store: begin
                st_en = 1'b1;
                st_addr = row.addr;
                st_data = row.data;
                st_mask = row.mask;
                #1;
                exp_stall = expect_stall(w);
                if (st_stall !== exp_stall) begin
                    report_mismatch(row.name, 64'(exp_stall), 64'(st_stall));
                end
                @(posedge clk);
                if (!exp_stall) begin
                    store_word(w, row.data, row.mask);
                end
            end
            op_load: begin
                ld_en = 1'b1;
                ld_addr = row.addr;
                exp_mask = buffered_mask(w);
                exp_data = buffered_data(w) & lanes(exp_mask);
                @(negedge clk);
                ld_en = 1'b0;
                if (ld_fwd_mask !== exp_mask) begin
                    report_mismatch(row.name, 64'(exp_mask), 64'(ld_fwd_mask));
                end
                if ((ld_fwd_data & lanes(exp_mask)) !== exp_data) begin
                    report_mismatch(row.name, exp_data, ld_fwd_data & lanes(exp_mask));
                end
            end
            op_ready: begin
                dc_ready = row.data[0];
                if (row.flag) begin
                    conflict_next = 1'b1;
                end
            end
            op_flush: flush = row.data[0];
            op_wait: begin
                cycles = 0;
                while ((word_count() > int'(row.addr) || inflight) && cycles < WAIT_LIMIT) begin
                    @(negedge clk);
                    #1;
                    cycles++;
                end
                if (word_count() > int'(row.addr) || inflight) begin
                    $display("timeout in %s: %0d words still buffered after %0d cycles",
                             row.name, word_count(), cycles);
                    other_errors++;
                    timed_out = 1'b1;
                end else if (row.addr == '0 && empty !== 1'b1) begin
                    report_mismatch(row.name, 64'(1), 64'(empty));
                end
            end
            default: ;
        endcase
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        flush = 1'b0;
        st_en = 1'b0;
        st_addr = '0;
        st_data = '0;
        st_mask = '0;
        ld_en = 1'b0;
        ld_addr = '0;
        dc_ready = 1'b0;
        dc_success = 1'b0;
        dc_conflict = 1'b0;
        value_errors = 0;
        other_errors = 0;
        timed_out = 1'b0;
        lfsr = 32'h7674_a9d1;
        conflict_next = 1'b0;
        retry_pending = 1'b0;
        retry_word = '0;
        inflight = 1'b0;
        inflight_word = '0;
        cur_name = "after_reset";
        build_table();

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        if (st_stall !== 1'b0) report_mismatch("after_reset", 64'(0), 64'(st_stall));
        if (dc_req !== 1'b0) report_mismatch("after_reset", 64'(0), 64'(dc_req));
        if (empty !== 1'b1) report_mismatch("after_reset", 64'(1), 64'(empty));
        if (ld_fwd_mask !== '0) report_mismatch("after_reset", 64'(0), 64'(ld_fwd_mask));

        for (int r = 0; r < rows.size() && !timed_out; r++) begin
            apply_row(rows[r]);
        end

        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+bench
logic/scb_pkg.sv
logic/scb_ifs.sv
logic/scb_tag_array.sv
logic/scb_data_array.sv
logic/scb_age_timer.sv
logic/scb_drain_fsm.sv
logic/store_commit_buffer.sv
bench/scb_tb.sv

//--- Makefile
# Verilator build and run of the store commit buffer testbench.

sim:
	verilator --binary --timing -j 0 -f build.f --top-module scb_tb -Mdir obj_dir
	./obj_dir/Vscb_tb > sim.log
	grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
